/* audio_pkg.sv */
`default_nettype none

package audio_pkg;

    // width of one audio sample at the output and in each voice
    localparam int sample_width = 16;

    typedef logic signed [sample_width-1:0] sample_t;

    // clamp limits for the mixer sum
    localparam sample_t sample_max = {1'b0, {(sample_width - 1){1'b1}}};
    localparam sample_t sample_min = {1'b1, {(sample_width - 1){1'b0}}};

endpackage

`default_nettype wire

/* wave_pkg.sv */
`default_nettype none

package wave_pkg;

    typedef enum logic [1:0]
    {
        silence  = 2'd0,
        sine     = 2'd1,
        triangle = 2'd2,
        square   = 2'd3
    } waveform_t;

    localparam int index_width = 9;

    // last entry of the quarter-period tables
    localparam logic [index_width-1:0] table_last_index = index_width'(26);

    localparam logic [audio_pkg::sample_width-1:0] square_level =
        audio_pkg::sample_width'(16355);
    localparam logic [audio_pkg::sample_width-1:0] triangle_step =
        audio_pkg::sample_width'(1053);

    // index is already shifted left by octave
    typedef struct packed
    {
        waveform_t                waveform;
        logic [index_width-1:0]   index;
    } table_req_t;

    typedef struct packed
    {
        logic [audio_pkg::sample_width-1:0] magnitude;
        logic [index_width-1:0]             last_index;
    } table_rsp_t;

endpackage

`default_nettype wire

/* wave_table.sv */
`timescale 1ns/1ps
`default_nettype none

module wave_table
(
    input  wave_pkg::table_req_t request,
    output wave_pkg::table_rsp_t response
);

    logic [audio_pkg::sample_width-1:0] sine_mag;
    logic [audio_pkg::sample_width-1:0] triangle_mag;
    logic                               in_range;

    assign in_range     = request.index <= wave_pkg::table_last_index;
    assign triangle_mag = audio_pkg::sample_width'(request.index) * wave_pkg::triangle_step;

    // quarter sine, 27 entries up to just below full scale
    always_comb
    begin
        case (request.index)
            0:       sine_mag = 16'd0;
            1:       sine_mag = 16'd953;
            2:       sine_mag = 16'd1902;
            3:       sine_mag = 16'd2845;
            4:       sine_mag = 16'd3778;
            5:       sine_mag = 16'd4699;
            6:       sine_mag = 16'd5603;
            7:       sine_mag = 16'd6489;
            8:       sine_mag = 16'd7353;
            9:       sine_mag = 16'd8191;
            10:      sine_mag = 16'd9003;
            11:      sine_mag = 16'd9783;
            12:      sine_mag = 16'd10531;
            13:      sine_mag = 16'd11243;
            14:      sine_mag = 16'd11917;
            15:      sine_mag = 16'd12550;
            16:      sine_mag = 16'd13141;
            17:      sine_mag = 16'd13688;
            18:      sine_mag = 16'd14188;
            19:      sine_mag = 16'd14640;
            20:      sine_mag = 16'd15043;
            21:      sine_mag = 16'd15395;
            22:      sine_mag = 16'd15695;
            23:      sine_mag = 16'd15941;
            24:      sine_mag = 16'd16134;
            25:      sine_mag = 16'd16272;
            26:      sine_mag = 16'd16355;
            default: sine_mag = 16'd0;
        endcase
    end

    always_comb
    begin
        response.last_index = wave_pkg::table_last_index;
        case (request.waveform)
            wave_pkg::sine:
                response.magnitude = sine_mag;
            wave_pkg::triangle:
                response.magnitude = in_range ? triangle_mag : '0;
            wave_pkg::square:
                response.magnitude = (request.index != '0) ? wave_pkg::square_level : '0;
            // silence
            default:
                response.magnitude = '0;
        endcase
    end

endmodule

`default_nettype wire

/* tone_voice.sv */
`timescale 1ns/1ps
`default_nettype none

module tone_voice
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sample_tick,
    input  wave_pkg::waveform_t   waveform,
    input  logic [2:0]            octave,
    output logic                  req,
    output wave_pkg::table_req_t  request,
    input  logic                  ack,
    input  wave_pkg::table_rsp_t  response,
    output audio_pkg::sample_t    voice_sample
);

    logic [wave_pkg::index_width-1:0] x;
    logic [wave_pkg::index_width-1:0] x_next;
    logic [wave_pkg::index_width-1:0] x_max;
    logic [wave_pkg::index_width-1:0] last_index;
    logic [1:0]                       quadrant;
    logic                             step_down;
    logic                             quadrant_end;
    audio_pkg::sample_t               magnitude;

    // higher octaves walk a shorter quarter period
    assign x_max = last_index >> octave;

    assign step_down    = (quadrant[0] && (x != '0)) || (x >= x_max);
    assign quadrant_end = (x == x_max) || (x == '0);

    // never step below zero, even when x_max collapses at high octaves
    assign x_next = (step_down && (x != '0)) ? x - 1'b1 : x + 1'b1;

    assign magnitude = audio_pkg::sample_t'(response.magnitude);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            x        <= wave_pkg::index_width'(1);
            quadrant <= 2'd0;
        end
        else if (sample_tick)
        begin
            x <= x_next;
            if (quadrant_end)
                quadrant <= quadrant + 2'd1;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            last_index <= wave_pkg::table_last_index;
        else if (ack)
            last_index <= response.last_index;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            req <= 1'b0;
        else if (sample_tick)
            req <= 1'b1;
        else if (ack)
            req <= 1'b0;
    end

    // lookup for the x stepped to on this tick, held until ack
    always_ff @(posedge clk)
    begin
        if (sample_tick)
        begin
            request.waveform <= waveform;
            request.index    <= x_next << octave;
        end
    end

    // second half-period is negated
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            voice_sample <= '0;
        else if (ack)
            voice_sample <= quadrant[1] ? -magnitude : magnitude;
    end

endmodule

`default_nettype wire

/* table_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module table_arbiter
#(
    parameter int voice_count = 2,
    parameter int tick_bits   = 6
)
(
    input  logic                  clk,
    input  logic                  reset,
    output logic                  sample_tick,
    input  logic                  req      [voice_count],
    input  wave_pkg::table_req_t  request  [voice_count],
    output logic                  ack      [voice_count],
    output wave_pkg::table_rsp_t  response
);

    localparam int ptr_width = (voice_count > 1) ? $clog2(voice_count) : 1;

    logic [tick_bits-1:0]  period_count;
    logic [ptr_width-1:0]  last_served;
    logic [ptr_width-1:0]  grant_idx;
    logic                  grant_valid;
    wave_pkg::table_req_t  table_req;
    wave_pkg::table_rsp_t  table_rsp;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            period_count <= '0;
            sample_tick  <= 1'b0;
        end
        else
        begin
            period_count <= period_count + 1'b1;
            sample_tick  <= &period_count;
        end
    end

    // a voice in its ack cycle still holds req, so skip it
    always_comb
    begin
        int idx;
        idx         = 0;
        grant_valid = 1'b0;
        grant_idx   = last_served;
        for (int k = 1; k <= voice_count; k++)
        begin
            idx = (int'(last_served) + k) % voice_count;
            if (!grant_valid && req[idx] && !ack[idx])
            begin
                grant_valid = 1'b1;
                grant_idx   = ptr_width'(idx);
            end
        end
    end

    assign table_req = request[grant_idx];

    wave_table u_table
    (
        .request  (table_req),
        .response (table_rsp)
    );

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            // first grant goes to voice 0
            last_served <= ptr_width'(voice_count - 1);
            for (int i = 0; i < voice_count; i++)
                ack[i] <= 1'b0;
        end
        else
        begin
            if (grant_valid)
                last_served <= grant_idx;
            for (int i = 0; i < voice_count; i++)
                ack[i] <= grant_valid && (grant_idx == ptr_width'(i));
        end
    end

    always_ff @(posedge clk)
    begin
        if (grant_valid)
            response <= table_rsp;
    end

endmodule

`default_nettype wire

/* voice_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module voice_mixer
#(
    parameter int voice_count = 2
)
(
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_tick,
    input  audio_pkg::sample_t  voice_sample [voice_count],
    output audio_pkg::sample_t  sample,
    output logic                sample_valid
);

    // room for the full sum before clamping
    localparam int acc_width = audio_pkg::sample_width + $clog2(voice_count + 1);

    typedef logic signed [acc_width-1:0] acc_t;

    acc_t               acc;
    audio_pkg::sample_t sum_sat;

    always_comb
    begin
        acc = '0;
        for (int i = 0; i < voice_count; i++)
            acc = acc + acc_t'(voice_sample[i]);
    end

    always_comb
    begin
        if (acc > acc_t'(audio_pkg::sample_max))
            sum_sat = audio_pkg::sample_max;
        else if (acc < acc_t'(audio_pkg::sample_min))
            sum_sat = audio_pkg::sample_min;
        else
            sum_sat = audio_pkg::sample_t'(acc[audio_pkg::sample_width-1:0]);
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            sample       <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            sample_valid <= sample_tick;
            if (sample_tick)
                sample <= sum_sat;
        end
    end

endmodule

`default_nettype wire

/* tone_synth_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tone_synth_top
#(
    parameter int voice_count = 2,
    parameter int tick_bits   = 6
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  wave_pkg::waveform_t  waveform [voice_count],
    input  logic [2:0]           octave   [voice_count],
    output audio_pkg::sample_t   sample,
    output logic                 sample_valid
);

    logic                  sample_tick;
    logic                  req          [voice_count];
    logic                  ack          [voice_count];
    wave_pkg::table_req_t  request      [voice_count];
    wave_pkg::table_rsp_t  response;
    audio_pkg::sample_t    voice_sample [voice_count];

    for (genvar i = 0; i < voice_count; i++)
    begin : g_voice
        tone_voice u_voice
        (
            .clk          (clk),
            .reset        (reset),
            .sample_tick  (sample_tick),
            .waveform     (waveform[i]),
            .octave       (octave[i]),
            .req          (req[i]),
            .request      (request[i]),
            .ack          (ack[i]),
            .response     (response),
            .voice_sample (voice_sample[i])
        );
    end

    table_arbiter
    #(
        .voice_count (voice_count),
        .tick_bits   (tick_bits)
    )
    u_arbiter
    (
        .clk         (clk),
        .reset       (reset),
        .sample_tick (sample_tick),
        .req         (req),
        .request     (request),
        .ack         (ack),
        .response    (response)
    );

    voice_mixer
    #(
        .voice_count (voice_count)
    )
    u_mixer
    (
        .clk          (clk),
        .reset        (reset),
        .sample_tick  (sample_tick),
        .voice_sample (voice_sample),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

endmodule

`default_nettype wire

/* tone_synth_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tone_synth_tb;

    localparam int voice_count = 2;
    localparam int tick_bits   = 4;
    localparam int last_index  = 26;
    localparam int index_mask  = (1 << wave_pkg::index_width) - 1;

    // samples per test, also used to size the timeout
    localparam int silence_samples  = 20;
    localparam int square_samples   = 110;
    localparam int tri_low_samples  = 208;
    localparam int tri_high_samples = 48;
    localparam int sine_samples     = 120;
    localparam int dual_sq_samples  = 110;
    localparam int dual_tri_samples = 104;
    localparam int dual_sin_samples = 120;
    localparam int total_samples    = silence_samples + square_samples + tri_low_samples
                                    + tri_high_samples + sine_samples + dual_sq_samples
                                    + dual_tri_samples + dual_sin_samples;
    localparam int cycle_limit      = total_samples * (1 << tick_bits) + 1000;

    // quarter sine, kept apart from the ROM
    localparam int sine_quarter [27] = '{
        0, 953, 1902, 2845, 3778, 4699, 5603, 6489, 7353, 8191,
        9003, 9783, 10531, 11243, 11917, 12550, 13141, 13688, 14188, 14640,
        15043, 15395, 15695, 15941, 16134, 16272, 16355
    };

    logic                 clk;
    logic                 reset;
    wave_pkg::waveform_t  waveform [voice_count];
    logic [2:0]           octave   [voice_count];
    audio_pkg::sample_t   sample;
    logic                 sample_valid;

    int     model_x  [voice_count];
    int     model_q  [voice_count];
    int     model_vs [voice_count];
    int     predicted;
    int     check_count;
    int     error_count;
    int     cycle_count;
    integer seed;

    tone_synth_top
    #(
        .voice_count (voice_count),
        .tick_bits   (tick_bits)
    )
    uut
    (
        .clk          (clk),
        .reset        (reset),
        .waveform     (waveform),
        .octave       (octave),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // run limit
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        check_count++;
        if (expected != actual)
        begin
            error_count++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, error_count - errors_before);
    endtask

    function automatic int magnitude_for(input wave_pkg::waveform_t w, input int idx);
        case (w)
            wave_pkg::sine:
                return (idx <= last_index) ? sine_quarter[idx] : 0;
            wave_pkg::triangle:
                return (idx <= last_index) ? idx * int'(wave_pkg::triangle_step) : 0;
            wave_pkg::square:
                return (idx != 0) ? int'(wave_pkg::square_level) : 0;
            default:
                return 0;
        endcase
    endfunction

    function automatic int saturate(input int value);
        if (value > int'(audio_pkg::sample_max))
            return int'(audio_pkg::sample_max);
        if (value < int'(audio_pkg::sample_min))
            return int'(audio_pkg::sample_min);
        return value;
    endfunction

    // one tick of every voice, then the sum the mixer shows next period
    task automatic advance_model();
        int oct;
        int x_top;
        int next_x;
        int mag;
        int sum;
        sum = 0;
        for (int v = 0; v < voice_count; v++)
        begin
            oct   = int'(octave[v]);
            x_top = last_index >> oct;
            if (model_x[v] == 0)
                next_x = 1;
            else if ((model_q[v] % 2 == 1) || (model_x[v] >= x_top))
                next_x = model_x[v] - 1;
            else
                next_x = model_x[v] + 1;
            // quadrant ends at the top or at zero
            if ((model_x[v] == x_top) || (model_x[v] == 0))
                model_q[v] = (model_q[v] + 1) % 4;
            model_x[v]  = next_x;
            mag         = magnitude_for(waveform[v], (next_x << oct) & index_mask);
            model_vs[v] = (model_q[v] >= 2) ? -mag : mag;
            sum         = sum + model_vs[v];
        end
        predicted = saturate(sum);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        for (int v = 0; v < voice_count; v++)
        begin
            model_x[v]  = 1;
            model_q[v]  = 0;
            model_vs[v] = 0;
        end
        predicted = 0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // returns 1 ns after the edge that raised sample_valid
    task automatic wait_valid();
        @(posedge clk);
        #1;
        while (!sample_valid)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_samples(input string name, input int count);
        for (int i = 0; i < count; i++)
        begin
            wait_valid();
            check_value(name, predicted, int'(sample));
            advance_model();
        end
    endtask

    task automatic set_voices(input wave_pkg::waveform_t w0, input wave_pkg::waveform_t w1,
                              input logic [2:0] oct0, input logic [2:0] oct1);
        waveform[0] = w0;
        waveform[1] = w1;
        octave[0]   = oct0;
        octave[1]   = oct1;
    endtask

    task automatic test_reset_silence();
        int errors_before;
        errors_before = error_count;
        set_voices(wave_pkg::silence, wave_pkg::silence, 3'd0, 3'd0);
        apply_reset();
        // well before the first tick
        repeat (8)
        begin
            @(posedge clk);
            #1;
            check_value("reset_silence", 0, int'(sample_valid));
            check_value("reset_silence", 0, int'(sample));
        end
        run_samples("reset_silence", silence_samples);
        report_test("reset_silence", errors_before);
    endtask

    task automatic test_square_voice();
        int errors_before;
        errors_before = error_count;
        set_voices(wave_pkg::square, wave_pkg::silence, 3'd0, 3'd0);
        apply_reset();
        run_samples("square_voice0", square_samples);
        report_test("square_voice0", errors_before);
    endtask

    task automatic test_triangle_octaves();
        int errors_before;
        errors_before = error_count;
        set_voices(wave_pkg::triangle, wave_pkg::silence, 3'd0, 3'd0);
        apply_reset();
        run_samples("triangle_octaves", tri_low_samples);
        // switch octave without a reset
        octave[0] = 3'd2;
        run_samples("triangle_octaves", tri_high_samples);
        report_test("triangle_octaves", errors_before);
    endtask

    task automatic test_sine_voice();
        int errors_before;
        errors_before = error_count;
        set_voices(wave_pkg::silence, wave_pkg::sine, 3'd0, 3'd0);
        apply_reset();
        run_samples("sine_voice1", sine_samples);
        report_test("sine_voice1", errors_before);
    endtask

    task automatic test_dual_voices();
        int errors_before;
        logic [2:0] oct0;
        logic [2:0] oct1;
        errors_before = error_count;
        set_voices(wave_pkg::square, wave_pkg::square, 3'd0, 3'd0);
        apply_reset();
        run_samples("dual_voices", dual_sq_samples);
        // triangle peaks clip at both limits
        set_voices(wave_pkg::triangle, wave_pkg::triangle, 3'd0, 3'd0);
        apply_reset();
        run_samples("dual_voices", dual_tri_samples);
        oct0 = 3'($random(seed) & 3);
        oct1 = 3'($random(seed) & 3);
        set_voices(wave_pkg::sine, wave_pkg::sine, oct0, oct1);
        apply_reset();
        run_samples("dual_voices", dual_sin_samples);
        report_test("dual_voices", errors_before);
    endtask

    initial
    begin
        reset       = 1'b1;
        seed        = 32'hd2fe_b634;
        check_count = 0;
        error_count = 0;
        cycle_count = 0;
        predicted   = 0;
        for (int v = 0; v < voice_count; v++)
        begin
            waveform[v] = wave_pkg::silence;
            octave[v]   = 3'd0;
        end

        test_reset_silence();
        test_square_voice();
        test_triangle_octaves();
        test_sine_voice();
        test_dual_voices();

        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tone_synth.f */
audio_pkg.sv
wave_pkg.sv
wave_table.sv
tone_voice.sv
table_arbiter.sv
voice_mixer.sv
tone_synth_top.sv
tone_synth_tb.sv

/* run_tone_synth.sh */
#!/bin/sh
# build and run the tone synthesizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tone_synth.f --top-module tone_synth_tb -o tone_synth_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tone_synth_sim > tone_synth.log 2>&1
status=$?
cat tone_synth.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" tone_synth.log; then
    exit 0
else
    echo "pass message not found in tone_synth.log"
    exit 1
fi
